/* src.f */
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/phaseSequencer.sv
verilog/controlEncoder.sv
verilog/controlUnit.sv
tests/clockGen.sv
tests/controlChecker.sv
tests/controlUnitTb.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - verilog/ctrlPkg.sv
  - verilog/instrDecoder.sv
  - verilog/phaseSequencer.sv
  - verilog/controlEncoder.sv
  - verilog/controlUnit.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/controlChecker.sv
      - tests/controlUnitTb.sv

/* tests/controlUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb;

    localparam int fetchWaitCycles = 3;
    localparam int resetCycles = 8;
    localparam int instrCount = 200;
    // Halt and reset pulse cost at most two cycles more than an execute sequence
    localparam int timeoutLimit = resetCycles + instrCount * (fetchWaitCycles + 6)
                                  + instrCount * 2 + 100;

    logic clk;
    logic porReset;
    logic pulseReset;
    logic reset;
    ctrlPkg::opcode_t opcode;
    ctrlPkg::funct_t funct;
    logic pcWrite;
    logic irWrite;
    logic abWrite;
    logic aluOutWrite;
    logic regWrite;
    ctrlPkg::regDst_t regDst;
    ctrlPkg::aluSrcA_t aluSrcA;
    ctrlPkg::aluSrcB_t aluSrcB;
    ctrlPkg::aluOp_t aluOp;
    logic resetReq;
    logic fetchStart;
    logic halted;
    logic isReset;
    int errorCount;
    int cycleCount;
    int haltWait;
    integer seed;

    clockGen #(.periodNs(40), .resetCycles(resetCycles)) clocks (.clk(clk), .reset(porReset));

    assign reset = porReset | pulseReset;

    controlUnit #(.fetchWaitCycles(fetchWaitCycles)) UUT (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .pcWrite(pcWrite), .irWrite(irWrite), .abWrite(abWrite),
        .aluOutWrite(aluOutWrite), .regWrite(regWrite), .regDst(regDst),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp), .resetReq(resetReq)
    );

    controlChecker #(.fetchWaitCycles(fetchWaitCycles)) outputCheck (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .pcWrite(pcWrite), .irWrite(irWrite), .abWrite(abWrite),
        .aluOutWrite(aluOutWrite), .regWrite(regWrite), .regDst(regDst),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp), .resetReq(resetReq),
        .fetchStart(fetchStart), .halted(halted), .errorCount(errorCount)
    );

    // About four in five draws are supported instructions
    task automatic drawInstruction(output logic resetOp);
        int pick;
        pick = $unsigned($random(seed)) % 10;
        opcode = ctrlPkg::opRType;
        funct = ctrlPkg::funct_t'($random(seed));
        case (pick)
            0, 1: funct = ctrlPkg::fnAdd;
            2, 3: funct = ctrlPkg::fnSub;
            4, 5: funct = ctrlPkg::fnAnd;
            6: opcode = ctrlPkg::opAddi;
            7: opcode = ctrlPkg::opReset;
            8: begin
                opcode = ctrlPkg::opcode_t'($random(seed));
                if (opcode == ctrlPkg::opRType || opcode == ctrlPkg::opAddi ||
                    opcode == ctrlPkg::opReset) begin
                    opcode = 6'h23; // Load word
                end
            end
            default: begin
                if (funct == ctrlPkg::fnAdd || funct == ctrlPkg::fnSub ||
                    funct == ctrlPkg::fnAnd) begin
                    funct = 6'h21;
                end
            end
        endcase
        resetOp = (opcode == ctrlPkg::opReset);
    endtask

    initial begin
        seed = 32'hd876f114;
        pulseReset = 1'b0;
        opcode = '0;
        funct = '0;
        @(posedge clk);
        wait (porReset === 1'b0);
        for (int i = 0; i < instrCount; i++) begin
            while (!fetchStart) @(negedge clk);
            drawInstruction(isReset);
            @(negedge clk);
            if (isReset) begin
                while (!halted) @(negedge clk);
                haltWait = $unsigned($random(seed)) % 3;
                repeat (haltWait) @(negedge clk);
                pulseReset = 1'b1;
                repeat (2) @(negedge clk);
                pulseReset = 1'b0;
            end
        end
        while (!fetchStart) @(negedge clk);
        repeat (2) @(negedge clk);
        @(posedge clk); // Last falling edge compare is done
        outputCheck.printSummary();
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
        outputCheck.printSummary();
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/controlChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module controlChecker #(
    parameter int fetchWaitCycles = 3
) (
    input wire clk,
    input wire reset,
    input wire ctrlPkg::opcode_t opcode,
    input wire ctrlPkg::funct_t funct,
    input wire pcWrite,
    input wire irWrite,
    input wire abWrite,
    input wire aluOutWrite,
    input wire regWrite,
    input wire ctrlPkg::regDst_t regDst,
    input wire ctrlPkg::aluSrcA_t aluSrcA,
    input wire ctrlPkg::aluSrcB_t aluSrcB,
    input wire ctrlPkg::aluOp_t aluOp,
    input wire resetReq,
    output logic fetchStart,
    output logic halted,
    output int errorCount
);

    ctrlPkg::phase_t phase;
    ctrlPkg::instrKind_t kind; // Held through the execute steps
    int step;
    int checkCount;
    logic resetSeen;
    logic prevReset;
    logic [4:0] expStrobes; // pc, ir, ab, aluOut, reg
    ctrlPkg::regDst_t expDst;
    ctrlPkg::aluSrcA_t expSrcA;
    ctrlPkg::aluSrcB_t expSrcB;
    ctrlPkg::aluOp_t expOp;
    logic expResetReq;

    function automatic ctrlPkg::instrKind_t decodeKind(input ctrlPkg::opcode_t op,
                                                       input ctrlPkg::funct_t fn);
        if (op == ctrlPkg::opAddi) return ctrlPkg::kindAddi;
        if (op == ctrlPkg::opReset) return ctrlPkg::kindReset;
        if (op != ctrlPkg::opRType) return ctrlPkg::kindNone;
        if (fn == ctrlPkg::fnAdd) return ctrlPkg::kindAdd;
        if (fn == ctrlPkg::fnSub) return ctrlPkg::kindSub;
        if (fn == ctrlPkg::fnAnd) return ctrlPkg::kindAnd;
        return ctrlPkg::kindNone;
    endfunction

    task automatic compareValue(input string name, input logic [7:0] actual,
                                input logic [7:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s: expected 0x%0h, actual 0x%0h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    task automatic printSummary();
        $display("Checked %0d output values, %0d errors", checkCount, errorCount);
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        resetSeen = 1'b0;
        prevReset = 1'b0;
        phase = ctrlPkg::phaseReset;
        step = 0;
        kind = ctrlPkg::kindNone;
    end

    assign fetchStart = resetSeen && phase == ctrlPkg::phaseFetch && step == 0;
    assign halted = resetSeen && phase == ctrlPkg::phaseHalt;

    always @(posedge clk) begin
        prevReset <= reset;
        if (reset) begin
            resetSeen <= 1'b1;
            step <= 0;
            // Reset request first and fetch step 0 while reset stays high
            phase <= prevReset ? ctrlPkg::phaseFetch : ctrlPkg::phaseReset;
        end else if (phase == ctrlPkg::phaseFetch && step == fetchWaitCycles + 2) begin
            step <= 0;
            kind <= decodeKind(opcode, funct);
            case (decodeKind(opcode, funct))
                ctrlPkg::kindReset: phase <= ctrlPkg::phaseHalt;
                ctrlPkg::kindNone: phase <= ctrlPkg::phaseFetch;
                default: phase <= ctrlPkg::phaseExec;
            endcase
        end else if ((phase == ctrlPkg::phaseExec && step == 2) ||
                     phase == ctrlPkg::phaseReset) begin
            phase <= ctrlPkg::phaseFetch;
            step <= 0;
        end else if (phase != ctrlPkg::phaseHalt) begin
            step <= step + 1;
        end
    end

    always_comb begin
        expStrobes = '0;
        expDst = ctrlPkg::dstRt;
        expSrcA = ctrlPkg::srcAPc;
        expSrcB = ctrlPkg::srcBReg;
        expOp = ctrlPkg::aluNone;
        expResetReq = phase == ctrlPkg::phaseReset || phase == ctrlPkg::phaseHalt;
        if (phase == ctrlPkg::phaseFetch && step <= fetchWaitCycles) begin
            expSrcB = ctrlPkg::srcBFour; // PC + 4
            expOp = ctrlPkg::aluAdd;
            if (step == fetchWaitCycles) expStrobes = 5'b11010;
        end else if (phase == ctrlPkg::phaseFetch && step == fetchWaitCycles + 1) begin
            expStrobes = 5'b00100;
        end else if (phase == ctrlPkg::phaseExec && kind == ctrlPkg::kindAddi) begin
            if (step < 2) begin
                expSrcA = ctrlPkg::srcAReg;
                expSrcB = ctrlPkg::srcBImm;
                expOp = ctrlPkg::aluAdd;
                expStrobes = (step == 1) ? 5'b00011 : 5'b00010;
            end
        end else if (phase == ctrlPkg::phaseExec) begin
            expSrcA = ctrlPkg::srcAReg;
            expOp = (kind == ctrlPkg::kindSub) ? ctrlPkg::aluSub :
                    (kind == ctrlPkg::kindAnd) ? ctrlPkg::aluAnd : ctrlPkg::aluAdd;
            expDst = (step == 0) ? ctrlPkg::dstRt : ctrlPkg::dstRd;
            expStrobes = (step == 0) ? 5'b00010 : (step == 1) ? 5'b00001 : 5'b00000;
        end
    end

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (resetSeen) begin
            compareValue("pcWrite", pcWrite, expStrobes[4]);
            compareValue("irWrite", irWrite, expStrobes[3]);
            compareValue("abWrite", abWrite, expStrobes[2]);
            compareValue("aluOutWrite", aluOutWrite, expStrobes[1]);
            compareValue("regWrite", regWrite, expStrobes[0]);
            compareValue("regDst", regDst, expDst);
            compareValue("aluSrcA", aluSrcA, expSrcA);
            compareValue("aluSrcB", aluSrcB, expSrcB);
            compareValue("aluOp", aluOp, expOp);
            compareValue("resetReq", resetReq, expResetReq);
        end
    end

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int periodNs = 40,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0; // Released on a falling edge like all other inputs
    end

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit #(
    parameter int fetchWaitCycles = 3 // Instruction memory wait cycles
) (
    input wire clk,
    input wire reset,

    input wire ctrlPkg::opcode_t opcode,
    input wire ctrlPkg::funct_t funct,

    output logic pcWrite,
    output logic irWrite,
    output logic abWrite,
    output logic aluOutWrite,
    output logic regWrite,
    output ctrlPkg::regDst_t regDst,
    output ctrlPkg::aluSrcA_t aluSrcA,
    output ctrlPkg::aluSrcB_t aluSrcB,
    output ctrlPkg::aluOp_t aluOp,
    output logic resetReq
);

    ctrlPkg::phase_t nextPhase;
    ctrlPkg::step_t nextStep;
    ctrlPkg::instrKind_t kind;

    phaseSequencer #(
        .fetchWaitCycles(fetchWaitCycles)
    ) sequencer (
        .clk(clk),
        .reset(reset),
        .kind(kind),
        .nextPhase(nextPhase),
        .nextStep(nextStep)
    );

    // Sequencer picks the decoded kind at the decode step
    instrDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .kind(kind)
    );

    controlEncoder #(
        .fetchWaitCycles(fetchWaitCycles)
    ) encoder (
        .clk(clk),
        .nextPhase(nextPhase),
        .nextStep(nextStep),
        .nextKind(kind),
        .pcWrite(pcWrite),
        .irWrite(irWrite),
        .abWrite(abWrite),
        .aluOutWrite(aluOutWrite),
        .regWrite(regWrite),
        .regDst(regDst),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .aluOp(aluOp),
        .resetReq(resetReq)
    );

endmodule

`default_nettype wire

/* verilog/controlEncoder.sv */
`timescale 1ns/1ns
`default_nettype none

module controlEncoder #(
    parameter int fetchWaitCycles = 3
) (
    input wire clk,

    input wire ctrlPkg::phase_t nextPhase,
    input wire ctrlPkg::step_t nextStep,
    input wire ctrlPkg::instrKind_t nextKind,

    output logic pcWrite,
    output logic irWrite,
    output logic abWrite,
    output logic aluOutWrite,
    output logic regWrite,
    output ctrlPkg::regDst_t regDst,
    output ctrlPkg::aluSrcA_t aluSrcA,
    output ctrlPkg::aluSrcB_t aluSrcB,
    output ctrlPkg::aluOp_t aluOp,
    output logic resetReq
);

    localparam ctrlPkg::step_t irStep = ctrlPkg::step_t'(fetchWaitCycles);
    localparam ctrlPkg::step_t abStep = ctrlPkg::step_t'(fetchWaitCycles + 1);

    ctrlPkg::instrKind_t heldKind;
    ctrlPkg::instrKind_t kindNow;
    logic execEntry;

    // R-type instructions share one sequence and differ only in the ALU op
    function automatic ctrlPkg::aluOp_t rTypeOp(input ctrlPkg::instrKind_t k);
        case (k)
            ctrlPkg::kindSub: rTypeOp = ctrlPkg::aluSub;
            ctrlPkg::kindAnd: rTypeOp = ctrlPkg::aluAnd;
            default: rTypeOp = ctrlPkg::aluAdd;
        endcase
    endfunction

    assign execEntry = (nextPhase == ctrlPkg::phaseExec) && (nextStep == '0);
    assign kindNow = execEntry ? nextKind : heldKind; // Opcode may change after decode

    always_ff @(posedge clk) begin
        if (execEntry) begin
            heldKind <= nextKind;
        end
    end

    always_ff @(posedge clk) begin
        pcWrite <= 1'b0;
        irWrite <= 1'b0;
        abWrite <= 1'b0;
        aluOutWrite <= 1'b0;
        regWrite <= 1'b0;
        regDst <= ctrlPkg::dstRt;
        aluSrcA <= ctrlPkg::srcAPc;
        aluSrcB <= ctrlPkg::srcBReg;
        aluOp <= ctrlPkg::aluNone;
        resetReq <= 1'b0;

        case (nextPhase)
            ctrlPkg::phaseReset,
            ctrlPkg::phaseHalt: begin
                resetReq <= 1'b1;
            end

            ctrlPkg::phaseFetch: begin
                if (nextStep <= irStep) begin
                    // PC + 4 on the ALU while memory settles
                    aluSrcA <= ctrlPkg::srcAPc;
                    aluSrcB <= ctrlPkg::srcBFour;
                    aluOp <= ctrlPkg::aluAdd;
                    if (nextStep == irStep) begin
                        pcWrite <= 1'b1;
                        irWrite <= 1'b1;
                        aluOutWrite <= 1'b1;
                    end
                end else if (nextStep == abStep) begin
                    abWrite <= 1'b1;
                end
                // Decode step leaves everything idle
            end

            ctrlPkg::phaseExec: begin
                case (kindNow)
                    ctrlPkg::kindAdd,
                    ctrlPkg::kindSub,
                    ctrlPkg::kindAnd: begin
                        aluSrcA <= ctrlPkg::srcAReg;
                        aluSrcB <= ctrlPkg::srcBReg;
                        aluOp <= rTypeOp(kindNow);
                        if (nextStep == 3'd0) begin
                            aluOutWrite <= 1'b1;
                        end else begin
                            regDst <= ctrlPkg::dstRd;
                            regWrite <= (nextStep == 3'd1); // Writeback
                        end
                    end

                    ctrlPkg::kindAddi: begin
                        if (nextStep != 3'd2) begin
                            aluSrcA <= ctrlPkg::srcAReg;
                            aluSrcB <= ctrlPkg::srcBImm;
                            aluOp <= ctrlPkg::aluAdd;
                            aluOutWrite <= 1'b1;
                            regWrite <= (nextStep == 3'd1);
                        end
                    end

                    default: begin
                        aluOp <= ctrlPkg::aluNone;
                    end
                endcase
            end

            default: begin
                resetReq <= 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/phaseSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module phaseSequencer #(
    parameter int fetchWaitCycles = 3
) (
    input wire clk,
    input wire reset,

    input wire ctrlPkg::instrKind_t kind,

    output ctrlPkg::phase_t nextPhase,
    output ctrlPkg::step_t nextStep
);

    // Fetch ends with the A/B latch step and then the decode step
    localparam ctrlPkg::step_t decodeStep = ctrlPkg::step_t'(fetchWaitCycles + 2);
    localparam ctrlPkg::step_t execLastStep = ctrlPkg::step_t'(2);

    ctrlPkg::phase_t phase;
    ctrlPkg::step_t step;
    logic resetHeld; // Reset was high at the previous edge

    always_comb begin
        nextPhase = phase;
        nextStep = step + 1'b1;

        if (reset) begin
            nextStep = '0;
            // First reset cycle requests reset and later ones park at fetch step 0
            if (resetHeld) begin
                nextPhase = ctrlPkg::phaseFetch;
            end else begin
                nextPhase = ctrlPkg::phaseReset;
            end
        end else begin
            case (phase)
                ctrlPkg::phaseReset: begin
                    nextPhase = ctrlPkg::phaseFetch;
                    nextStep = '0;
                end

                ctrlPkg::phaseFetch: begin
                    if (step == decodeStep) begin
                        nextStep = '0;
                        case (kind)
                            ctrlPkg::kindAdd,
                            ctrlPkg::kindSub,
                            ctrlPkg::kindAnd,
                            ctrlPkg::kindAddi: nextPhase = ctrlPkg::phaseExec;
                            ctrlPkg::kindReset: nextPhase = ctrlPkg::phaseHalt;
                            default: nextPhase = ctrlPkg::phaseFetch; // Unsupported so refetch
                        endcase
                    end
                end

                ctrlPkg::phaseExec: begin
                    if (step == execLastStep) begin
                        nextPhase = ctrlPkg::phaseFetch;
                        nextStep = '0;
                    end
                end

                ctrlPkg::phaseHalt: begin
                    nextStep = '0; // Wait here for external reset
                end

                default: begin
                    nextPhase = ctrlPkg::phaseFetch;
                    nextStep = '0;
                end
            endcase
        end
    end

    // Encoder registers the same next values
    always_ff @(posedge clk) begin
        resetHeld <= reset;
        phase <= nextPhase;
        step <= nextStep;
    end

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input wire ctrlPkg::opcode_t opcode,
    input wire ctrlPkg::funct_t funct,

    output ctrlPkg::instrKind_t kind
);

    always_comb begin
        kind = ctrlPkg::kindNone;

        case (opcode)
            ctrlPkg::opRType: begin
                case (funct)
                    ctrlPkg::fnAdd: kind = ctrlPkg::kindAdd;
                    ctrlPkg::fnSub: kind = ctrlPkg::kindSub;
                    ctrlPkg::fnAnd: kind = ctrlPkg::kindAnd;
                    default: kind = ctrlPkg::kindNone; // Other R-type functs
                endcase
            end

            ctrlPkg::opAddi: begin
                kind = ctrlPkg::kindAddi;
            end

            ctrlPkg::opReset: begin
                kind = ctrlPkg::kindReset;
            end

            default: begin
                kind = ctrlPkg::kindNone;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Step counter wide enough for fetch wait values up to 4
    localparam int stepWidth = 3;
    typedef logic [stepWidth-1:0] step_t;

    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opAddi = 6'h08;
    localparam opcode_t opReset = 6'h3f;

    localparam funct_t fnAdd = 6'h20;
    localparam funct_t fnSub = 6'h22;
    localparam funct_t fnAnd = 6'h24;

    // ALU operand A select
    typedef logic [1:0] aluSrcA_t;
    localparam aluSrcA_t srcAPc = 2'b00;
    localparam aluSrcA_t srcAReg = 2'b01;

    // ALU operand B select
    typedef logic [1:0] aluSrcB_t;
    localparam aluSrcB_t srcBReg = 2'b00;
    localparam aluSrcB_t srcBFour = 2'b01;
    localparam aluSrcB_t srcBImm = 2'b10;

    typedef logic [2:0] aluOp_t;
    localparam aluOp_t aluNone = 3'd0;
    localparam aluOp_t aluAdd = 3'd1;
    localparam aluOp_t aluSub = 3'd2;
    localparam aluOp_t aluAnd = 3'd3;

    // Register file write destination
    typedef logic [1:0] regDst_t;
    localparam regDst_t dstRt = 2'd0;
    localparam regDst_t dstRd = 2'd1;

    // Halt is only left through the external reset
    typedef enum logic [1:0] {
        phaseReset,
        phaseFetch,
        phaseExec,
        phaseHalt
    } phase_t;

    typedef enum logic [2:0] {
        kindNone,
        kindAdd,
        kindSub,
        kindAnd,
        kindAddi,
        kindReset
    } instrKind_t;

endpackage

`default_nettype wire
